//--- Bender.yml
package:
  name: datapath

sources:
  - logic/cpuPkg.sv
  - logic/regBankIf.sv
  - logic/selectEncode.sv
  - logic/gpRegister.sv
  - logic/busMux.sv
  - logic/alu.sv
  - logic/specialRegs.sv
  - logic/memoryUnit.sv
  - logic/conFf.sv
  - logic/datapath.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/datapathTb.sv

//--- all.f
logic/cpuPkg.sv
logic/regBankIf.sv
logic/selectEncode.sv
logic/gpRegister.sv
logic/busMux.sv
logic/alu.sv
logic/specialRegs.sv
logic/memoryUnit.sv
logic/conFf.sv
logic/datapath.sv
test/clockGen.sv
test/datapathTb.sv

//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpuPkg::word_t  y,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_e op,
    input  logic           incPc,
    output cpuPkg::dword_t result
);
    import cpuPkg::*;

    localparam int ShiftWidth = $clog2(WordWidth);

    logic [ShiftWidth-1:0]        shamt;
    logic [2*WordWidth-1:0]       yTwice;
    logic [2*WordWidth-1:0]       rotRight;
    logic [2*WordWidth-1:0]       rotLeft;
    logic signed [2*WordWidth-1:0] product;
    word_t                        lowWord;

    assign shamt = b[ShiftWidth-1:0];   // Shift count from the low bits of b

    // Rotates come out of a doubled copy of y
    assign yTwice   = {y, y};
    assign rotRight = yTwice >> shamt;
    assign rotLeft  = yTwice << shamt;

    assign product = $signed(y) * $signed(b);

    always_comb begin
        if (incPc) begin
            lowWord = b + 1'b1;     // PC increment overrides op
        end else begin
            case (op)
                aluAdd:  lowWord = y + b;
                aluSub:  lowWord = y - b;
                aluAnd:  lowWord = y & b;
                aluOr:   lowWord = y | b;
                aluShr:  lowWord = y >> shamt;
                aluShra: lowWord = $signed(y) >>> shamt;
                aluShl:  lowWord = y << shamt;
                aluRor:  lowWord = rotRight[WordWidth-1:0];
                aluRol:  lowWord = rotLeft[2*WordWidth-1:WordWidth];
                aluMul:  lowWord = product[WordWidth-1:0];
                aluNeg:  lowWord = -b;
                aluNot:  lowWord = ~b;
                default: lowWord = '0;
            endcase
        end
    end

    //////////////////////////////
    // 64-bit result for Z
    //////////////////////////////

    always_comb begin
        if (op == aluMul && !incPc) begin
            result = product;
        end else begin
            // High half carries the sign of the low half
            result = {{WordWidth{lowWord[WordWidth-1]}}, lowWord};
        end
    end

endmodule

`default_nettype wire

//--- logic/busMux.sv
`timescale 1ns/1ns
`default_nettype none

module busMux (
    regBankIf.mux         bank,
    input  logic          pcOut,
    input  logic          zHighOut,
    input  logic          zLowOut,
    input  logic          hiOut,
    input  logic          loOut,
    input  logic          mdrOut,
    input  logic          inPortOut,
    input  logic          cOut,
    input  cpuPkg::word_t pc,
    input  cpuPkg::word_t zHigh,
    input  cpuPkg::word_t zLow,
    input  cpuPkg::word_t hi,
    input  cpuPkg::word_t lo,
    input  cpuPkg::word_t mdr,
    input  cpuPkg::word_t inPort,
    input  cpuPkg::word_t cSignExt
);
    import cpuPkg::*;

    localparam int NumSrc = NumRegs + 8;
    localparam int SelWidth = $clog2(NumSrc);

    logic [NumSrc-1:0]   srcEn;
    word_t               srcWord [NumSrc];
    logic [SelWidth-1:0] srcSel;
    logic                anyEn;

    // Registers take the low indices, special sources follow
    assign srcEn = {cOut, inPortOut, mdrOut, loOut, hiOut, zLowOut, zHighOut, pcOut, bank.rOut};

    always_comb begin
        for (int i = 0; i < NumRegs; i++) begin
            srcWord[i] = bank.regData[i];
        end
        if (bank.baOut) begin
            srcWord[0] = '0;        // R0 reads as zero for base addressing
        end
        srcWord[NumRegs]     = pc;
        srcWord[NumRegs + 1] = zHigh;
        srcWord[NumRegs + 2] = zLow;
        srcWord[NumRegs + 3] = hi;
        srcWord[NumRegs + 4] = lo;
        srcWord[NumRegs + 5] = mdr;
        srcWord[NumRegs + 6] = inPort;
        srcWord[NumRegs + 7] = cSignExt;
    end

    // Encode the single enabled source
    always_comb begin
        srcSel = '0;
        for (int i = 0; i < NumSrc; i++) begin
            if (srcEn[i]) begin
                srcSel = SelWidth'(i);
            end
        end
    end

    assign anyEn = |srcEn;
    assign bank.busData = anyEn ? srcWord[srcSel] : '0;    // Idle bus is zero

endmodule

`default_nettype wire

//--- logic/conFf.sv
`timescale 1ns/1ns
`default_nettype none

module conFf (
    input  logic           clk,
    input  logic           rstN,
    input  logic           conIn,
    input  cpuPkg::instr_u instr,
    input  cpuPkg::word_t  busData,
    output logic           conOut
);
    import cpuPkg::*;

    logic [1:0] condSel;
    logic       busZero;
    logic       condMet;

    assign condSel = instr.b.c2[1:0];
    assign busZero = (busData == '0);

    always_comb begin
        case (condSel)
            2'd0:    condMet = busZero;                 // Branch if zero
            2'd1:    condMet = !busZero;                // Branch if nonzero
            2'd2:    condMet = !busData[WordWidth-1];   // Sign bit clear
            default: condMet = busData[WordWidth-1];    // Negative
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            conOut <= 1'b0;
        end else if (conIn) begin
            conOut <= condMet;
        end
    end

endmodule

`default_nettype wire

//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    parameter int WordWidth = 32;
    parameter int NumRegs = 16;     // Register fields are 4 bits wide

    typedef logic [WordWidth-1:0] word_t;

    // Z and the multiplier output
    typedef struct packed {
        word_t high;
        word_t low;
    } dword_t;

    typedef enum logic [4:0] {
        aluAdd  = 5'd3,
        aluSub  = 5'd4,
        aluAnd  = 5'd5,
        aluOr   = 5'd6,
        aluShr  = 5'd7,
        aluShra = 5'd8,
        aluShl  = 5'd9,
        aluRor  = 5'd10,
        aluRol  = 5'd11,
        aluMul  = 5'd12,
        aluNeg  = 5'd13,
        aluNot  = 5'd14
    } aluOp_e;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } instrR_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] constant;
    } instrI_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  c2;        // Low two bits pick the branch condition
        logic [18:0] constant;
    } instrB_t;

    typedef union packed {
        instrR_t r;
        instrI_t i;
        instrB_t b;
    } instr_u;

endpackage

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath #(
    parameter int MemDepth = 512
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           pcIn,
    input  logic           irIn,
    input  logic           yIn,
    input  logic           zIn,
    input  logic           hiIn,
    input  logic           loIn,
    input  logic           marIn,
    input  logic           mdrIn,
    input  logic           outPortIn,
    input  logic           pcOut,
    input  logic           zHighOut,
    input  logic           zLowOut,
    input  logic           hiOut,
    input  logic           loOut,
    input  logic           mdrOut,
    input  logic           inPortOut,
    input  logic           cOut,
    input  logic           incPc,
    input  cpuPkg::aluOp_e aluOp,
    input  logic           read,
    input  logic           write,
    input  logic           gra,
    input  logic           grb,
    input  logic           grc,
    input  logic           rIn,
    input  logic           rOut,
    input  logic           baOut,
    input  logic           conIn,
    output logic           conOut,
    input  cpuPkg::word_t  inPortData,
    output cpuPkg::word_t  outPortData,
    output cpuPkg::word_t  busData
);
    import cpuPkg::*;

    word_t  pc;
    word_t  y;
    word_t  zHigh;
    word_t  zLow;
    word_t  hi;
    word_t  lo;
    word_t  inPort;
    word_t  mdr;
    word_t  cSignExt;
    instr_u instr;
    dword_t aluResult;

    regBankIf bank ();

    //////////////////////////////
    // General registers
    //////////////////////////////

    selectEncode u_selectEncode (
        .instr    (instr),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .rIn      (rIn),
        .rOut     (rOut),
        .baOut    (baOut),
        .bank     (bank.encoder),
        .cSignExt (cSignExt)
    );

    for (genvar i = 0; i < NumRegs; i++) begin : gRegs
        gpRegister u_gpRegister (
            .clk  (clk),
            .rstN (rstN),
            .load (bank.rIn[i]),
            .d    (bank.busData),
            .q    (bank.regData[i])
        );
    end

    //////////////////////////////
    // Bus and ALU
    //////////////////////////////

    busMux u_busMux (
        .bank      (bank.mux),
        .pcOut     (pcOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .mdrOut    (mdrOut),
        .inPortOut (inPortOut),
        .cOut      (cOut),
        .pc        (pc),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .hi        (hi),
        .lo        (lo),
        .mdr       (mdr),
        .inPort    (inPort),
        .cSignExt  (cSignExt)
    );

    assign busData = bank.busData;

    alu u_alu (
        .y      (y),
        .b      (bank.busData),
        .op     (aluOp),
        .incPc  (incPc),
        .result (aluResult)
    );

    specialRegs u_specialRegs (
        .clk         (clk),
        .rstN        (rstN),
        .pcIn        (pcIn),
        .irIn        (irIn),
        .yIn         (yIn),
        .zIn         (zIn),
        .hiIn        (hiIn),
        .loIn        (loIn),
        .outPortIn   (outPortIn),
        .busData     (bank.busData),
        .aluResult   (aluResult),
        .inPortData  (inPortData),
        .pc          (pc),
        .y           (y),
        .zHigh       (zHigh),
        .zLow        (zLow),
        .hi          (hi),
        .lo          (lo),
        .inPort      (inPort),
        .outPortData (outPortData),
        .instr       (instr)
    );

    memoryUnit #(
        .MemDepth (MemDepth)
    ) u_memoryUnit (
        .clk     (clk),
        .rstN    (rstN),
        .marIn   (marIn),
        .mdrIn   (mdrIn),
        .read    (read),
        .write   (write),
        .busData (bank.busData),
        .mdr     (mdr)
    );

    conFf u_conFf (
        .clk     (clk),
        .rstN    (rstN),
        .conIn   (conIn),
        .instr   (instr),
        .busData (bank.busData),
        .conOut  (conOut)
    );

endmodule

`default_nettype wire

//--- logic/gpRegister.sv
`timescale 1ns/1ns
`default_nettype none

module gpRegister (
    input  logic          clk,
    input  logic          rstN,
    input  logic          load,
    input  cpuPkg::word_t d,
    output cpuPkg::word_t q
);
    import cpuPkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (load) begin
            q <= d;     // Takes the bus on its rIn strobe
        end
    end

endmodule

`default_nettype wire

//--- logic/memoryUnit.sv
`timescale 1ns/1ns
`default_nettype none

module memoryUnit #(
    parameter int MemDepth = 512
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          marIn,
    input  logic          mdrIn,
    input  logic          read,
    input  logic          write,
    input  cpuPkg::word_t busData,
    output cpuPkg::word_t mdr
);
    import cpuPkg::*;

    localparam int AddrWidth = $clog2(MemDepth);

    logic [AddrWidth-1:0] mar;
    word_t                ram [MemDepth];
    word_t                ramData;

    assign ramData = ram[mar];  // Asynchronous read

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= busData[AddrWidth-1:0];  // Word address from the low bits
            end
            if (mdrIn) begin
                mdr <= read ? ramData : busData;
            end
        end
    end

    // Stores the MDR value loaded in an earlier step
    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar] <= mdr;
        end
    end

endmodule

`default_nettype wire

//--- logic/regBankIf.sv
`timescale 1ns/1ns
`default_nettype none

interface regBankIf;
    import cpuPkg::*;

    logic [NumRegs-1:0] rIn;    // One-hot load strobes
    logic [NumRegs-1:0] rOut;   // One-hot output strobes
    logic               baOut;
    word_t              busData;
    word_t              regData [NumRegs];

    modport encoder (
        output rIn, rOut, baOut
    );

    modport mux (
        input  rOut, baOut, regData,
        output busData
    );

    // Register side of the bank
    modport bank (
        input  rIn, busData,
        output regData
    );

endinterface

`default_nettype wire

//--- logic/selectEncode.sv
`timescale 1ns/1ns
`default_nettype none

module selectEncode (
    input  cpuPkg::instr_u instr,
    input  logic           gra,
    input  logic           grb,
    input  logic           grc,
    input  logic           rIn,
    input  logic           rOut,
    input  logic           baOut,
    regBankIf.encoder      bank,
    output cpuPkg::word_t  cSignExt
);
    import cpuPkg::*;

    localparam int ConstWidth = 19;

    logic [3:0]         regSel;
    logic               anyGr;
    logic [NumRegs-1:0] regOneHot;

    // Only one of gra, grb, grc is high in a step
    assign regSel = ({4{gra}} & instr.r.ra)
                  | ({4{grb}} & instr.r.rb)
                  | ({4{grc}} & instr.r.rc);
    assign anyGr = gra | grb | grc;

    always_comb begin
        regOneHot = '0;
        if (anyGr) begin
            regOneHot[regSel] = 1'b1;
        end
    end

    assign bank.rIn   = rIn ? regOneHot : '0;
    assign bank.rOut  = (rOut || baOut) ? regOneHot : '0;  // baOut uses the same choice
    assign bank.baOut = baOut;

    // Constant field of the I view, sign extended to a full word
    assign cSignExt = {{(WordWidth - ConstWidth){instr.i.constant[ConstWidth-1]}},
                       instr.i.constant};

endmodule

`default_nettype wire

//--- logic/specialRegs.sv
`timescale 1ns/1ns
`default_nettype none

module specialRegs (
    input  logic           clk,
    input  logic           rstN,
    input  logic           pcIn,
    input  logic           irIn,
    input  logic           yIn,
    input  logic           zIn,
    input  logic           hiIn,
    input  logic           loIn,
    input  logic           outPortIn,
    input  cpuPkg::word_t  busData,
    input  cpuPkg::dword_t aluResult,
    input  cpuPkg::word_t  inPortData,
    output cpuPkg::word_t  pc,
    output cpuPkg::word_t  y,
    output cpuPkg::word_t  zHigh,
    output cpuPkg::word_t  zLow,
    output cpuPkg::word_t  hi,
    output cpuPkg::word_t  lo,
    output cpuPkg::word_t  inPort,
    output cpuPkg::word_t  outPortData,
    output cpuPkg::instr_u instr
);
    import cpuPkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc          <= '0;
            instr       <= '0;
            y           <= '0;
            zHigh       <= '0;
            zLow        <= '0;
            hi          <= '0;
            lo          <= '0;
            inPort      <= '0;
            outPortData <= '0;
        end else begin
            inPort <= inPortData;   // Input port is sampled every cycle

            if (pcIn) pc <= busData;
            if (irIn) instr <= busData;
            if (yIn) y <= busData;     // Y holds the first ALU operand
            if (zIn) begin
                zHigh <= aluResult.high;
                zLow  <= aluResult.low;
            end
            if (hiIn) hi <= busData;
            if (loIn) lo <= busData;
            if (outPortIn) outPortData <= busData;
        end
    end

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int PeriodNs = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PeriodNs / 2) clk = ~clk;   // Free running, 50% duty

endmodule

`default_nettype wire

//--- test/datapathTb.sv
`timescale 1ns/1ns
`default_nettype none

module datapathTb;
    import cpuPkg::*;

    localparam int ClockPeriod = 4;
    localparam int ResetCycles = 10;
    localparam int StepDelay   = 1;    // Inputs change this long after the rising edge
    localparam int MemDepth    = 512;
    localparam int MaxRows     = 48;
    localparam int StepsPerRow = 40;
    localparam logic [31:0] Seed = 32'h20ab_8dc4;

    localparam word_t ProgAddr = 32'h0000_01f0;    // Program word lives here
    localparam logic [4:0] OpLd = 5'd0;
    localparam logic [4:0] OpSt = 5'd2;
    localparam logic [4:0] OpBr = 5'd18;

    typedef enum {kindReg, kindAlu, kindInc, kindMem, kindBase, kindCond} rowKind_e;

    logic   clk;
    logic   rstN;
    logic   pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn;
    logic   pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut;
    logic   incPc;
    aluOp_e aluOp;
    logic   read, write;
    logic   gra, grb, grc, rIn, rOut, baOut;
    logic   conIn;
    logic   conOut;
    word_t  inPortData;
    word_t  outPortData;
    word_t  busData;

    // Stimulus and expected values, one entry per row
    string       rowName    [MaxRows];
    rowKind_e    rowKind    [MaxRows];
    aluOp_e      rowOp      [MaxRows];
    logic [3:0]  rowField   [MaxRows];  // Register index or c2
    word_t       rowA       [MaxRows];
    word_t       rowB       [MaxRows];
    logic [18:0] rowConst   [MaxRows];
    word_t       rowExp     [MaxRows];
    word_t       rowExpHigh [MaxRows];
    logic        rowFlag    [MaxRows];
    int          rowCount;
    logic        tableReady;

    int errorCount;
    int checkCount;

    clockGen #(
        .PeriodNs (ClockPeriod)
    ) u_clockGen (
        .clk (clk)
    );

    datapath #(
        .MemDepth (MemDepth)
    ) u_datapath (
        .clk (clk), .rstN (rstN),
        .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .hiIn (hiIn), .loIn (loIn), .marIn (marIn), .mdrIn (mdrIn),
        .outPortIn (outPortIn),
        .pcOut (pcOut), .zHighOut (zHighOut), .zLowOut (zLowOut),
        .hiOut (hiOut), .loOut (loOut), .mdrOut (mdrOut),
        .inPortOut (inPortOut), .cOut (cOut),
        .incPc (incPc), .aluOp (aluOp),
        .read (read), .write (write),
        .gra (gra), .grb (grb), .grc (grc),
        .rIn (rIn), .rOut (rOut), .baOut (baOut),
        .conIn (conIn), .conOut (conOut),
        .inPortData (inPortData), .outPortData (outPortData),
        .busData (busData)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    //////////////////////////////
    // Instruction words
    //////////////////////////////

    function automatic word_t encodeR(input logic [3:0] ra, input logic [3:0] rb,
                                      input logic [3:0] rc);
        instr_u w;
        w      = '0;
        w.r.ra = ra;
        w.r.rb = rb;
        w.r.rc = rc;
        return w;
    endfunction

    function automatic word_t encodeI(input logic [4:0] opcode, input logic [3:0] ra,
                                      input logic [3:0] rb, input logic [18:0] constant);
        instr_u w;
        w            = '0;
        w.i.opcode   = opcode;
        w.i.ra       = ra;
        w.i.rb       = rb;
        w.i.constant = constant;
        return w;
    endfunction

    function automatic word_t encodeB(input logic [3:0] c2);
        instr_u w;
        w          = '0;
        w.b.opcode = OpBr;
        w.b.c2     = c2;
        return w;
    endfunction

    //////////////////////////////
    // Control steps
    //////////////////////////////

    task automatic clearStrobes();
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        {incPc, read, write, conIn} = '0;
        {gra, grb, grc, rIn, rOut, baOut} = '0;
        aluOp = aluAdd;
    endtask

    // Strobes set before this act on the coming edge
    task automatic endStep();
        @(posedge clk);
        #StepDelay;
        clearStrobes();
    endtask

    // Idle cycle so the input port register picks the value up
    task automatic driveInPort(input word_t value);
        inPortData = value;
        endStep();
    endtask

    task automatic loadIr(input word_t value);
        driveInPort(value);
        inPortOut = 1'b1;
        irIn      = 1'b1;
        endStep();
    endtask

    task automatic loadReg(input logic [3:0] idx, input word_t value);
        loadIr(encodeR(idx, 4'h0, 4'h0));
        driveInPort(value);
        inPortOut = 1'b1;
        gra       = 1'b1;
        rIn       = 1'b1;
        endStep();
    endtask

    task automatic readReg(output word_t value);
        gra       = 1'b1;
        rOut      = 1'b1;
        outPortIn = 1'b1;
        endStep();
        value = outPortData;
    endtask

    task automatic storeWord(input word_t addr, input word_t data);
        driveInPort(addr);
        inPortOut = 1'b1;
        marIn     = 1'b1;
        endStep();
        driveInPort(data);
        inPortOut = 1'b1;
        mdrIn     = 1'b1;
        endStep();
        write = 1'b1;
        endStep();
    endtask

    // Rb (R0 reads zero) plus constant into MAR, bus checked on the way
    task automatic computeEa(input string name, input word_t expected);
        grb   = 1'b1;
        baOut = 1'b1;
        yIn   = 1'b1;
        endStep();
        cOut  = 1'b1;
        aluOp = aluAdd;
        zIn   = 1'b1;
        endStep();
        zLowOut = 1'b1;
        marIn   = 1'b1;
        #StepDelay;
        checkWord({name, " address"}, expected, busData);
        endStep();
    endtask

    //////////////////////////////
    // Row runners
    //////////////////////////////

    task automatic runRegRow(input int i);
        word_t value;
        loadReg(rowField[i], rowA[i]);
        readReg(value);
        checkWord(rowName[i], rowA[i], value);
    endtask

    task automatic runAluRow(input int i);
        word_t value;
        loadReg(4'd2, rowA[i]);
        loadReg(4'd3, rowB[i]);
        loadIr(encodeR(4'd1, 4'd2, 4'd3));
        grb  = 1'b1;
        rOut = 1'b1;
        yIn  = 1'b1;
        endStep();
        grc   = 1'b1;
        rOut  = 1'b1;
        aluOp = rowOp[i];
        incPc = (rowKind[i] == kindInc);
        zIn   = 1'b1;
        endStep();
        zLowOut = 1'b1;
        gra     = 1'b1;
        rIn     = 1'b1;
        endStep();
        readReg(value);
        checkWord({rowName[i], " low"}, rowExp[i], value);
        zHighOut = 1'b1;    // Z high reaches the port through HI
        hiIn     = 1'b1;
        endStep();
        hiOut     = 1'b1;
        outPortIn = 1'b1;
        endStep();
        checkWord({rowName[i], " high"}, rowExpHigh[i], outPortData);
    endtask

    task automatic runMemRow(input int i);
        word_t value;
        loadReg(4'd5, rowA[i]);
        loadReg(4'd6, rowB[i]);
        storeWord(ProgAddr, encodeI(OpSt, 4'd5, 4'd6, rowConst[i]));
        read  = 1'b1;   // Fetch the store instruction back into IR
        mdrIn = 1'b1;
        endStep();
        mdrOut = 1'b1;
        irIn   = 1'b1;
        endStep();
        computeEa(rowName[i], rowExp[i]);
        gra   = 1'b1;
        rOut  = 1'b1;
        mdrIn = 1'b1;
        endStep();
        write = 1'b1;
        endStep();
        // Load back into R0 from the address given by the testbench
        driveInPort(rowExp[i]);
        inPortOut = 1'b1;
        marIn     = 1'b1;
        endStep();
        read  = 1'b1;
        mdrIn = 1'b1;
        endStep();
        loadIr(encodeI(OpLd, 4'd0, 4'd6, rowConst[i]));
        mdrOut = 1'b1;
        gra    = 1'b1;
        rIn    = 1'b1;
        endStep();
        readReg(value);
        checkWord({rowName[i], " data"}, rowA[i], value);
    endtask

    task automatic runBaseRow(input int i);
        loadReg(4'd0, rowB[i]);
        loadIr(encodeI(OpLd, 4'd4, 4'd0, rowConst[i]));
        computeEa(rowName[i], rowExp[i]);
    endtask

    task automatic runCondRow(input int i);
        loadIr(encodeB(rowField[i]));
        driveInPort(rowA[i]);
        inPortOut = 1'b1;
        conIn     = 1'b1;
        endStep();
        checkFlag(rowName[i], rowFlag[i], conOut);
    endtask

    //////////////////////////////
    // Table
    //////////////////////////////

    task automatic appendRow(input string name, input rowKind_e kind);
        rowName[rowCount]    = name;
        rowKind[rowCount]    = kind;
        rowOp[rowCount]      = aluAdd;
        rowField[rowCount]   = '0;
        rowA[rowCount]       = '0;
        rowB[rowCount]       = '0;
        rowConst[rowCount]   = '0;
        rowExp[rowCount]     = '0;
        rowExpHigh[rowCount] = '0;
        rowFlag[rowCount]    = 1'b0;
        rowCount++;
    endtask

    task automatic addRegRow(input string name, input logic [3:0] idx, input word_t value);
        appendRow(name, kindReg);
        rowField[rowCount-1] = idx;
        rowA[rowCount-1]     = value;
    endtask

    task automatic addAluRow(input string name, input rowKind_e kind, input aluOp_e op,
                             input word_t a, input word_t b,
                             input word_t expLow, input word_t expHigh);
        appendRow(name, kind);
        rowOp[rowCount-1]      = op;
        rowA[rowCount-1]       = a;
        rowB[rowCount-1]       = b;
        rowExp[rowCount-1]     = expLow;
        rowExpHigh[rowCount-1] = expHigh;
    endtask

    task automatic addAddrRow(input string name, input rowKind_e kind, input word_t a,
                              input word_t b, input logic [18:0] c, input word_t ea);
        appendRow(name, kind);
        rowA[rowCount-1]     = a;
        rowB[rowCount-1]     = b;
        rowConst[rowCount-1] = c;
        rowExp[rowCount-1]   = ea;
    endtask

    task automatic addCondRow(input string name, input logic [3:0] c2, input word_t value,
                              input logic flag);
        appendRow(name, kindCond);
        rowField[rowCount-1] = c2;
        rowA[rowCount-1]     = value;
        rowFlag[rowCount-1]  = flag;
    endtask

    task automatic fillTable();
        word_t randA;
        word_t randB;
        word_t randSum;
        for (int k = 0; k < 4; k++) begin
            addRegRow($sformatf("reg round trip %0d", k), 4'($urandom_range(15, 0)),
                      $urandom());
        end
        addAluRow("add", kindAlu, aluAdd, 32'h0000_1234, 32'h0000_0f0f,
                  32'h0000_2143, 32'h0000_0000);
        addAluRow("sub", kindAlu, aluSub, 32'h0000_0005, 32'h0000_0009,
                  32'hffff_fffc, 32'hffff_ffff);
        addAluRow("and", kindAlu, aluAnd, 32'hf0f0_f0f0, 32'hff00_ff00,
                  32'hf000_f000, 32'hffff_ffff);
        addAluRow("or", kindAlu, aluOr, 32'hf0f0_0000, 32'h0000_0f0f,
                  32'hf0f0_0f0f, 32'hffff_ffff);
        addAluRow("shr", kindAlu, aluShr, 32'h8000_0010, 32'h0000_0004,
                  32'h0800_0001, 32'h0000_0000);
        addAluRow("shra", kindAlu, aluShra, 32'h8000_0010, 32'h0000_0004,
                  32'hf800_0001, 32'hffff_ffff);
        addAluRow("shl", kindAlu, aluShl, 32'h0000_00ff, 32'h0000_0024,   // Count 36 acts as 4
                  32'h0000_0ff0, 32'h0000_0000);
        addAluRow("ror", kindAlu, aluRor, 32'h1234_5678, 32'h0000_0008,
                  32'h7812_3456, 32'h0000_0000);
        addAluRow("rol", kindAlu, aluRol, 32'h1234_5678, 32'h0000_0004,
                  32'h2345_6781, 32'h0000_0000);
        addAluRow("mul signed", kindAlu, aluMul, 32'hffff_fffd, 32'h0001_0000,
                  32'hfffd_0000, 32'hffff_ffff);
        addAluRow("mul wide", kindAlu, aluMul, 32'h0002_0003, 32'h0001_0004,
                  32'h000b_000c, 32'h0000_0002);
        addAluRow("neg", kindAlu, aluNeg, 32'h1111_1111, 32'h0000_0007,
                  32'hffff_fff9, 32'hffff_ffff);
        addAluRow("not", kindAlu, aluNot, 32'h1111_1111, 32'h0f0f_0000,
                  32'hf0f0_ffff, 32'hffff_ffff);
        addAluRow("incPc", kindInc, aluSub, 32'h0000_0055, 32'h0000_00ff,
                  32'h0000_0100, 32'h0000_0000);
        randA   = $urandom();
        randB   = $urandom();
        randSum = randA + randB;
        addAluRow("add random", kindAlu, aluAdd, randA, randB,
                  randSum, {WordWidth{randSum[WordWidth-1]}});
        addAddrRow("store load", kindMem, 32'hcafe_0001, 32'h0000_0040, 19'h0_0025,
                   32'h0000_0065);
        addAddrRow("store load negative c", kindMem, 32'h5a5a_a5a5, 32'h0000_0100,
                   19'h7_fff0, 32'h0000_00f0);
        addAddrRow("R0 base", kindBase, 32'h0, 32'h1234_5678, 19'h0_0033, 32'h0000_0033);
        // c2 upper bits vary on the zero rows and must be ignored
        addCondRow("zero on 0", 4'hc, 32'h0000_0000, 1'b1);
        addCondRow("zero on pos", 4'h0, 32'h0000_0015, 1'b0);
        addCondRow("zero on neg", 4'h0, 32'h8000_0003, 1'b0);
        addCondRow("nonzero on 0", 4'hd, 32'h0000_0000, 1'b0);
        addCondRow("nonzero on pos", 4'h1, 32'h0000_0015, 1'b1);
        addCondRow("nonzero on neg", 4'h1, 32'h8000_0003, 1'b1);
        addCondRow("positive on 0", 4'he, 32'h0000_0000, 1'b1);
        addCondRow("positive on pos", 4'h2, 32'h0000_0015, 1'b1);
        addCondRow("positive on neg", 4'h2, 32'h8000_0003, 1'b0);
        addCondRow("negative on 0", 4'hf, 32'h0000_0000, 1'b0);
        addCondRow("negative on pos", 4'h3, 32'h0000_0015, 1'b0);
        addCondRow("negative on neg", 4'h3, 32'h8000_0003, 1'b1);
    endtask

    task automatic runRow(input int i);
        case (rowKind[i])
            kindReg:  runRegRow(i);
            kindMem:  runMemRow(i);
            kindBase: runBaseRow(i);
            kindCond: runCondRow(i);
            default:  runAluRow(i);    // ALU and incPc rows
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(Seed));
        clearStrobes();
        inPortData = '0;
        rstN       = 1'b0;
        errorCount = 0;
        checkCount = 0;
        rowCount   = 0;
        tableReady = 1'b0;
        fillTable();
        tableReady = 1'b1;

        repeat (ResetCycles) @(posedge clk);
        #StepDelay;
        rstN = 1'b1;
        checkWord("reset outPortData", '0, outPortData);
        checkWord("reset busData", '0, busData);
        checkFlag("reset conOut", 1'b0, conOut);

        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Budget of steps per row plus reset and margin
    initial begin : watchdog
        longint limitNs;
        wait (tableReady);
        limitNs = (longint'(rowCount) * StepsPerRow + 20) * ClockPeriod;
        #(limitNs);
        $display("Watchdog expired: the run did not finish within %0d ns", limitNs);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
